/* common/mycore_cfg.svh */
`ifndef MYCORE_CFG_SVH
`define MYCORE_CFG_SVH

// data and address width
`define MYCORE_XLEN 32

// architectural register file
`define MYCORE_REG_COUNT 32
`define MYCORE_REG_ADDR_W 5

// boot vector, first fetch after reset
`define MYCORE_RESET_PC 32'hbfc0_0000

`endif

/* common/mycore_pkg.sv */
package mycore_pkg;

`include "mycore_cfg.svh"

    typedef logic [`MYCORE_XLEN-1:0] word_t;
    typedef logic [`MYCORE_REG_ADDR_W-1:0] reg_addr_t;

    // decoded operation, anything unsupported ends up as op_nop
    typedef enum logic [3:0] {
        op_nop,
        op_addu,
        op_subu,
        op_and,
        op_or,
        op_slt,
        op_addiu,
        op_ori,
        op_lui,
        op_beq,
        op_bne,
        op_j
    } op_e;

    // instruction bus request tracking
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_request,
        fetch_wait
    } fetch_state_e;

endpackage

/* design/fetch/fetch_unit.sv */
`timescale 1ns/1ns
`include "mycore_cfg.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              reset,
    output logic              ireq_valid,
    output mycore_pkg::word_t ireq_addr,
    input  logic              ireq_ready,
    input  logic              irsp_valid,
    input  mycore_pkg::word_t irsp_data,
    input  logic              redirect,
    input  mycore_pkg::word_t redirect_pc,
    output logic              f_valid,
    output mycore_pkg::word_t f_pc,
    output mycore_pkg::word_t f_instr
);

    mycore_pkg::fetch_state_e state;
    mycore_pkg::word_t pc;
    mycore_pkg::word_t pc_next;
    mycore_pkg::word_t req_addr;
    logic discard;
    logic accepted;
    logic rsp_kept;
    logic start_req;

    assign ireq_valid = (state == mycore_pkg::fetch_request);
    assign ireq_addr = req_addr;
    assign accepted = ireq_valid && ireq_ready;

    // a response seen during a redirect belongs to the squashed path
    assign rsp_kept = irsp_valid && !discard && !redirect;

    // new request goes out after reset or right after a response
    assign start_req = (state == mycore_pkg::fetch_idle) ||
                       (state == mycore_pkg::fetch_wait && irsp_valid);

    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (rsp_kept) begin
            pc_next = req_addr + 32'd4;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mycore_pkg::fetch_idle;
            pc <= `MYCORE_RESET_PC;
            discard <= 1'b0;
        end else begin
            pc <= pc_next;
            case (state)
                mycore_pkg::fetch_idle: state <= mycore_pkg::fetch_request;
                mycore_pkg::fetch_request: begin
                    if (accepted) begin
                        state <= mycore_pkg::fetch_wait;
                    end
                end
                mycore_pkg::fetch_wait: begin
                    if (irsp_valid) begin
                        state <= mycore_pkg::fetch_request;
                    end
                end
                default: state <= mycore_pkg::fetch_idle;
            endcase
            // pending or in-flight request on the old path gets dropped later
            if (redirect) begin
                discard <= !(state == mycore_pkg::fetch_wait && irsp_valid);
            end else if (irsp_valid) begin
                discard <= 1'b0;
            end
        end
    end

    // address is held while the request waits for ready
    always_ff @(posedge clk) begin
        if (start_req) begin
            req_addr <= pc_next;
        end
    end

    // fetch to decode register, a one cycle pulse per kept response
    always_ff @(posedge clk) begin
        if (reset) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= rsp_kept;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_kept) begin
            f_pc <= req_addr;
            f_instr <= irsp_data;
        end
    end

endmodule

/* design/decode.sv */
`timescale 1ns/1ns

module decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  f_valid,
    input  mycore_pkg::word_t     f_pc,
    input  mycore_pkg::word_t     f_instr,
    input  logic                  redirect,
    output mycore_pkg::reg_addr_t rs_addr,
    output mycore_pkg::reg_addr_t rt_addr,
    input  mycore_pkg::word_t     rs_value,
    input  mycore_pkg::word_t     rt_value,
    output logic                  x_valid,
    output mycore_pkg::op_e       x_op,
    output mycore_pkg::word_t     x_pc,
    output mycore_pkg::reg_addr_t x_rd,
    output mycore_pkg::word_t     x_a,
    output mycore_pkg::word_t     x_b,
    output mycore_pkg::word_t     x_imm,
    output mycore_pkg::word_t     x_target
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm16;
    mycore_pkg::reg_addr_t rd_field;
    mycore_pkg::op_e op;
    mycore_pkg::reg_addr_t dest;
    mycore_pkg::word_t imm;
    mycore_pkg::word_t pc_plus4;

    assign opcode = f_instr[31:26];
    assign funct = f_instr[5:0];
    assign imm16 = f_instr[15:0];
    assign rs_addr = f_instr[25:21];
    assign rt_addr = f_instr[20:16];
    assign rd_field = f_instr[15:11];
    assign pc_plus4 = f_pc + 32'd4;

    always_comb begin
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h21: op = mycore_pkg::op_addu;
                    6'h23: op = mycore_pkg::op_subu;
                    6'h24: op = mycore_pkg::op_and;
                    6'h25: op = mycore_pkg::op_or;
                    6'h2a: op = mycore_pkg::op_slt;
                    default: op = mycore_pkg::op_nop;
                endcase
            end
            6'h02: op = mycore_pkg::op_j;
            6'h04: op = mycore_pkg::op_beq;
            6'h05: op = mycore_pkg::op_bne;
            6'h09: op = mycore_pkg::op_addiu;
            6'h0d: op = mycore_pkg::op_ori;
            6'h0f: op = mycore_pkg::op_lui;
            default: op = mycore_pkg::op_nop;
        endcase
    end

    // destination and immediate by op, zero dest means no write
    always_comb begin
        dest = '0;
        imm = '0;
        case (op)
            mycore_pkg::op_addu, mycore_pkg::op_subu, mycore_pkg::op_and,
            mycore_pkg::op_or, mycore_pkg::op_slt: dest = rd_field;
            mycore_pkg::op_addiu: begin
                dest = rt_addr;
                imm = {{16{imm16[15]}}, imm16};
            end
            mycore_pkg::op_ori: begin
                dest = rt_addr;
                imm = {16'b0, imm16};
            end
            mycore_pkg::op_lui: begin
                dest = rt_addr;
                imm = {imm16, 16'b0};
            end
            // branch offset in words
            mycore_pkg::op_beq, mycore_pkg::op_bne: imm = {{14{imm16[15]}}, imm16, 2'b00};
            default: dest = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x_valid <= 1'b0;
            x_op <= mycore_pkg::op_nop;
        end else begin
            x_valid <= f_valid && !redirect;
            x_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        x_pc <= f_pc;
        x_rd <= dest;
        x_a <= rs_value;
        x_b <= rt_value;
        x_imm <= imm;
        x_target <= {pc_plus4[31:28], f_instr[25:0], 2'b00};
    end

endmodule

/* design/regfile.sv */
`timescale 1ns/1ns
`include "mycore_cfg.svh"

module regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  mycore_pkg::reg_addr_t rs_addr,
    input  mycore_pkg::reg_addr_t rt_addr,
    output mycore_pkg::word_t     rs_data,
    output mycore_pkg::word_t     rt_data,
    input  logic                  w_valid,
    input  mycore_pkg::reg_addr_t w_reg,
    input  mycore_pkg::word_t     w_data
);

    mycore_pkg::word_t regs [`MYCORE_REG_COUNT];

    // register zero is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MYCORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (w_valid && w_reg != '0) begin
            regs[w_reg] <= w_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

/* design/bypass.sv */
`timescale 1ns/1ns

module bypass (
    input  mycore_pkg::reg_addr_t rs_addr,
    input  mycore_pkg::reg_addr_t rt_addr,
    input  mycore_pkg::word_t     rs_data,
    input  mycore_pkg::word_t     rt_data,
    input  logic                  x_fwd_valid,
    input  mycore_pkg::reg_addr_t x_fwd_reg,
    input  mycore_pkg::word_t     x_fwd_data,
    input  logic                  w_valid,
    input  mycore_pkg::reg_addr_t w_reg,
    input  mycore_pkg::word_t     w_data,
    output mycore_pkg::word_t     rs_value,
    output mycore_pkg::word_t     rt_value
);

    // youngest producer wins, register zero never forwards
    function automatic mycore_pkg::word_t pick(
        input mycore_pkg::reg_addr_t addr,
        input mycore_pkg::word_t rf_data,
        input logic xv,
        input mycore_pkg::reg_addr_t xr,
        input mycore_pkg::word_t xd,
        input logic wv,
        input mycore_pkg::reg_addr_t wr,
        input mycore_pkg::word_t wd
    );
        if (addr == '0) return '0;
        if (xv && xr == addr) return xd;
        if (wv && wr == addr) return wd;
        return rf_data;
    endfunction

    always_comb begin
        rs_value = pick(rs_addr, rs_data, x_fwd_valid, x_fwd_reg, x_fwd_data,
                        w_valid, w_reg, w_data);
        rt_value = pick(rt_addr, rt_data, x_fwd_valid, x_fwd_reg, x_fwd_data,
                        w_valid, w_reg, w_data);
    end

endmodule

/* design/execute.sv */
`timescale 1ns/1ns

module execute (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  x_valid,
    input  mycore_pkg::op_e       x_op,
    input  mycore_pkg::word_t     x_pc,
    input  mycore_pkg::reg_addr_t x_rd,
    input  mycore_pkg::word_t     x_a,
    input  mycore_pkg::word_t     x_b,
    input  mycore_pkg::word_t     x_imm,
    input  mycore_pkg::word_t     x_target,
    output logic                  x_fwd_valid,
    output mycore_pkg::reg_addr_t x_fwd_reg,
    output mycore_pkg::word_t     x_fwd_data,
    output logic                  redirect,
    output mycore_pkg::word_t     redirect_pc,
    output logic                  w_valid,
    output mycore_pkg::word_t     w_pc,
    output mycore_pkg::reg_addr_t w_reg,
    output mycore_pkg::word_t     w_data
);

    mycore_pkg::word_t result;
    logic operands_equal;
    logic less_than;
    logic taken;
    logic writes;

    assign operands_equal = (x_a == x_b);
    assign less_than = $signed(x_a) < $signed(x_b);

    always_comb begin
        result = '0;
        case (x_op)
            mycore_pkg::op_addu: result = x_a + x_b;
            mycore_pkg::op_subu: result = x_a - x_b;
            mycore_pkg::op_and: result = x_a & x_b;
            mycore_pkg::op_or: result = x_a | x_b;
            mycore_pkg::op_slt: result[0] = less_than;
            mycore_pkg::op_addiu: result = x_a + x_imm;
            mycore_pkg::op_ori: result = x_a | x_imm;
            mycore_pkg::op_lui: result = x_imm;
            default: result = '0;
        endcase
    end

    always_comb begin
        case (x_op)
            mycore_pkg::op_beq: taken = operands_equal;
            mycore_pkg::op_bne: taken = !operands_equal;
            mycore_pkg::op_j: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // no delay slot, the instruction behind a taken branch is squashed
    assign redirect = x_valid && taken;
    assign redirect_pc = (x_op == mycore_pkg::op_j) ? x_target : x_pc + 32'd4 + x_imm;

    // decode leaves x_rd at zero for branches, jumps and no-ops
    assign writes = x_valid && (x_rd != '0);
    assign x_fwd_valid = writes;
    assign x_fwd_reg = x_rd;
    assign x_fwd_data = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            w_valid <= 1'b0;
        end else begin
            w_valid <= x_valid;
        end
    end

    always_ff @(posedge clk) begin
        w_pc <= x_pc;
        w_reg <= writes ? x_rd : '0;
        w_data <= writes ? result : '0;
    end

endmodule

/* design/mycore.sv */
`timescale 1ns/1ns

module mycore (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  ireq_valid,
    output mycore_pkg::word_t     ireq_addr,
    input  logic                  ireq_ready,
    input  logic                  irsp_valid,
    input  mycore_pkg::word_t     irsp_data,
    output logic                  commit_valid,
    output mycore_pkg::word_t     commit_pc,
    output mycore_pkg::reg_addr_t commit_reg,
    output mycore_pkg::word_t     commit_data
);

    // fetch to decode
    logic f_valid;
    mycore_pkg::word_t f_pc;
    mycore_pkg::word_t f_instr;

    // operand read
    mycore_pkg::reg_addr_t rs_addr;
    mycore_pkg::reg_addr_t rt_addr;
    mycore_pkg::word_t rs_data;
    mycore_pkg::word_t rt_data;
    mycore_pkg::word_t rs_value;
    mycore_pkg::word_t rt_value;

    // decode to execute
    logic x_valid;
    mycore_pkg::op_e x_op;
    mycore_pkg::word_t x_pc;
    mycore_pkg::reg_addr_t x_rd;
    mycore_pkg::word_t x_a;
    mycore_pkg::word_t x_b;
    mycore_pkg::word_t x_imm;
    mycore_pkg::word_t x_target;

    // execute stage forwarding and redirect
    logic x_fwd_valid;
    mycore_pkg::reg_addr_t x_fwd_reg;
    mycore_pkg::word_t x_fwd_data;
    logic redirect;
    mycore_pkg::word_t redirect_pc;

    fetch_unit fetch_unit_i (
        .clk(clk), .reset(reset),
        .ireq_valid(ireq_valid), .ireq_addr(ireq_addr), .ireq_ready(ireq_ready),
        .irsp_valid(irsp_valid), .irsp_data(irsp_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .f_valid(f_valid), .f_pc(f_pc), .f_instr(f_instr)
    );

    decode decode_i (
        .clk(clk), .reset(reset),
        .f_valid(f_valid), .f_pc(f_pc), .f_instr(f_instr), .redirect(redirect),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_value(rs_value), .rt_value(rt_value),
        .x_valid(x_valid), .x_op(x_op), .x_pc(x_pc), .x_rd(x_rd),
        .x_a(x_a), .x_b(x_b), .x_imm(x_imm), .x_target(x_target)
    );

    // the commit register doubles as the regfile write port
    regfile regfile_i (
        .clk(clk), .reset(reset),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .w_valid(commit_valid), .w_reg(commit_reg), .w_data(commit_data)
    );

    bypass bypass_i (
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .x_fwd_valid(x_fwd_valid), .x_fwd_reg(x_fwd_reg), .x_fwd_data(x_fwd_data),
        .w_valid(commit_valid), .w_reg(commit_reg), .w_data(commit_data),
        .rs_value(rs_value), .rt_value(rt_value)
    );

    execute execute_i (
        .clk(clk), .reset(reset),
        .x_valid(x_valid), .x_op(x_op), .x_pc(x_pc), .x_rd(x_rd),
        .x_a(x_a), .x_b(x_b), .x_imm(x_imm), .x_target(x_target),
        .x_fwd_valid(x_fwd_valid), .x_fwd_reg(x_fwd_reg), .x_fwd_data(x_fwd_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .w_valid(commit_valid), .w_pc(commit_pc), .w_reg(commit_reg), .w_data(commit_data)
    );

endmodule

/* dv/mycore_checker.sv */
`timescale 1ns/1ns

module mycore_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  ireq_valid,
    input mycore_pkg::word_t     ireq_addr,
    input logic                  ireq_ready,
    input logic                  irsp_valid,
    input logic                  redirect,
    input logic                  commit_valid,
    input mycore_pkg::reg_addr_t commit_reg,
    input mycore_pkg::word_t     commit_data
);

    // number of failed properties so far
    int error_count = 0;
    logic outstanding;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (ireq_valid && ireq_ready) begin
            outstanding <= 1'b1;
        end else if (irsp_valid) begin
            outstanding <= 1'b0;
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !ireq_valid && !commit_valid && !redirect)
        else begin
            $error("request, commit or redirect active right after reset");
            error_count++;
        end

    addr_held: assert property (@(posedge clk) disable iff (reset)
        ireq_valid && !ireq_ready |=> ireq_valid && $stable(ireq_addr))
        else begin
            $error("stalled instruction request dropped or changed its address");
            error_count++;
        end

    one_outstanding: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !ireq_valid)
        else begin
            $error("new instruction request before the previous response");
            error_count++;
        end

    zero_reg_data: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_reg == '0 |-> commit_data == '0)
        else begin
            $error("commit to register zero with nonzero data");
            error_count++;
        end

endmodule

bind mycore mycore_checker checker_i (
    .clk(clk), .reset(reset),
    .ireq_valid(ireq_valid), .ireq_addr(ireq_addr), .ireq_ready(ireq_ready),
    .irsp_valid(irsp_valid), .redirect(redirect),
    .commit_valid(commit_valid), .commit_reg(commit_reg), .commit_data(commit_data)
);

/* dv/mycore_tb.sv */
`timescale 1ns/1ns
`include "mycore_cfg.svh"

module mycore_tb;

    localparam int PROG_LEN = 19;
    localparam int COMMIT_TIMEOUT = 60;
    localparam int MAX_COMMITS = 64;
    localparam logic [31:0] END_PC = `MYCORE_RESET_PC + 32'd76;
    // five setup instructions, three loop passes of seven, five after the loop
    localparam int EXPECTED_COMMITS = 31;
    // r12 ends as the countdown sum 3 + 2 + 1 plus the zero counter
    localparam logic [31:0] FINAL_SUM = 32'd6;

    logic clk = 1'b0;
    logic reset;
    logic ireq_valid;
    mycore_pkg::word_t ireq_addr;
    logic ireq_ready;
    logic irsp_valid;
    mycore_pkg::word_t irsp_data;
    logic commit_valid;
    mycore_pkg::word_t commit_pc;
    mycore_pkg::reg_addr_t commit_reg;
    mycore_pkg::word_t commit_data;

    mycore_pkg::word_t prog [PROG_LEN];
    mycore_pkg::word_t model_regs [`MYCORE_REG_COUNT];
    mycore_pkg::word_t model_pc;
    mycore_pkg::word_t rsp_addr;
    int rsp_delay;
    int seed;
    logic first_accept;

    always #50 clk = ~clk;

    mycore mycore_i (
        .clk(clk), .reset(reset),
        .ireq_valid(ireq_valid), .ireq_addr(ireq_addr), .ireq_ready(ireq_ready),
        .irsp_valid(irsp_valid), .irsp_data(irsp_data),
        .commit_valid(commit_valid), .commit_pc(commit_pc),
        .commit_reg(commit_reg), .commit_data(commit_data)
    );

    function automatic mycore_pkg::word_t encode_r(input logic [5:0] funct,
            input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic mycore_pkg::word_t encode_i(input logic [5:0] opcode,
            input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic mycore_pkg::word_t encode_j(input mycore_pkg::word_t target);
        return {6'h02, target[27:2]};
    endfunction

    // words outside the program read as zero and decode as a no-op
    function automatic mycore_pkg::word_t fetch_word(input mycore_pkg::word_t addr);
        mycore_pkg::word_t offset;
        offset = addr - `MYCORE_RESET_PC;
        if (offset < 4 * PROG_LEN) begin
            return prog[offset[31:2]];
        end
        return '0;
    endfunction

    task automatic load_program();
        prog[0] = encode_i(6'h0f, 5'd1, 5'd0, 16'h1234);
        prog[1] = encode_i(6'h0d, 5'd1, 5'd1, 16'h5678);
        // r2 counts the loop down and r3 holds -1
        prog[2] = encode_i(6'h09, 5'd2, 5'd0, 16'd3);
        prog[3] = encode_i(6'h09, 5'd3, 5'd0, 16'hffff);
        prog[4] = encode_i(6'h09, 5'd0, 5'd0, 16'd5);
        // loop body is a chain of dependent ALU ops
        prog[5] = encode_r(6'h21, 5'd4, 5'd4, 5'd2);
        prog[6] = encode_r(6'h23, 5'd5, 5'd4, 5'd1);
        prog[7] = encode_r(6'h24, 5'd6, 5'd5, 5'd3);
        prog[8] = encode_r(6'h25, 5'd7, 5'd6, 5'd0);
        prog[9] = encode_r(6'h2a, 5'd8, 5'd3, 5'd2);
        prog[10] = encode_i(6'h09, 5'd2, 5'd2, 16'hffff);
        prog[11] = encode_i(6'h05, 5'd0, 5'd2, 16'hfff9);
        // the taken beq skips index 13 and the not-taken beq falls into the forward j
        prog[12] = encode_i(6'h04, 5'd0, 5'd2, 16'd1);
        prog[13] = encode_i(6'h09, 5'd9, 5'd0, 16'h0077);
        prog[14] = encode_i(6'h04, 5'd0, 5'd1, 16'd2);
        prog[15] = encode_j(`MYCORE_RESET_PC + 32'd68);
        prog[16] = encode_i(6'h09, 5'd10, 5'd0, 16'h0055);
        prog[17] = encode_r(6'h21, 5'd11, 5'd2, 5'd8);
        prog[18] = encode_r(6'h21, 5'd12, 5'd4, 5'd2);
    endtask

    // architectural model stepping one instruction per call in program order
    task automatic step_model(output mycore_pkg::word_t exp_pc,
            output mycore_pkg::reg_addr_t exp_reg, output mycore_pkg::word_t exp_data);
        mycore_pkg::word_t ins;
        mycore_pkg::word_t a;
        mycore_pkg::word_t b;
        mycore_pkg::word_t se;
        mycore_pkg::word_t res;
        mycore_pkg::word_t next_pc;
        mycore_pkg::reg_addr_t dst;
        ins = fetch_word(model_pc);
        a = model_regs[ins[25:21]];
        b = model_regs[ins[20:16]];
        se = {{16{ins[15]}}, ins[15:0]};
        dst = '0;
        res = '0;
        next_pc = model_pc + 32'd4;
        case (ins[31:26])
            6'h00: begin
                dst = ins[15:11];
                case (ins[5:0])
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h2a: res = {31'b0, $signed(a) < $signed(b)};
                    default: dst = '0;
                endcase
            end
            6'h02: next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            6'h04: if (a == b) next_pc = next_pc + {se[29:0], 2'b00};
            6'h05: if (a != b) next_pc = next_pc + {se[29:0], 2'b00};
            6'h09: begin
                dst = ins[20:16];
                res = a + se;
            end
            6'h0d: begin
                dst = ins[20:16];
                res = a | {16'b0, ins[15:0]};
            end
            6'h0f: begin
                dst = ins[20:16];
                res = {ins[15:0], 16'b0};
            end
            default: dst = '0;
        endcase
        if (dst == '0) begin
            res = '0;
        end else begin
            model_regs[dst] = res;
        end
        exp_pc = model_pc;
        exp_reg = dst;
        exp_data = res;
        model_pc = next_pc;
    endtask

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic wait_commit();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (mycore_i.checker_i.error_count != 0) begin
                $display("a bound checker assertion failed");
                stop_with_failure();
            end
        end while (!commit_valid && cycles < COMMIT_TIMEOUT);
        if (!commit_valid) begin
            $display("no commit_valid within %0d cycles", cycles);
            stop_with_failure();
        end
    endtask

    task automatic check_commit(input mycore_pkg::word_t exp_pc,
            input mycore_pkg::reg_addr_t exp_reg, input mycore_pkg::word_t exp_data);
        assert (commit_pc == exp_pc) else begin
            $display("ERR commit_pc expected %h actual %h", exp_pc, commit_pc);
            stop_with_failure();
        end
        assert (commit_reg == exp_reg) else begin
            $display("ERR commit_reg expected %h actual %h", exp_reg, commit_reg);
            stop_with_failure();
        end
        assert (commit_data == exp_data) else begin
            $display("ERR commit_data expected %h actual %h", exp_data, commit_data);
            stop_with_failure();
        end
    endtask

    // instruction memory with random ready and 1 to 4 cycles of latency
    always @(negedge clk) begin
        irsp_valid = 1'b0;
        if (rsp_delay > 0) begin
            rsp_delay = rsp_delay - 1;
            if (rsp_delay == 0) begin
                irsp_valid = 1'b1;
                irsp_data = fetch_word(rsp_addr);
            end
        end
        ireq_ready = ({$random(seed)} % 4) != 0;
        if (ireq_valid && ireq_ready) begin
            if (first_accept) begin
                assert (ireq_addr == `MYCORE_RESET_PC) else begin
                    $display("ERR ireq_addr expected %h actual %h",
                             `MYCORE_RESET_PC, ireq_addr);
                    stop_with_failure();
                end
                first_accept = 1'b0;
            end
            rsp_addr = ireq_addr;
            rsp_delay = 1 + int'({$random(seed)} % 4);
        end
    end

    initial begin
        mycore_pkg::word_t exp_pc;
        mycore_pkg::reg_addr_t exp_reg;
        mycore_pkg::word_t exp_data;
        int commits;
        reset = 1'b1;
        ireq_ready = 1'b0;
        irsp_valid = 1'b0;
        irsp_data = '0;
        rsp_delay = 0;
        first_accept = 1'b1;
        seed = 21713;
        load_program();
        for (int i = 0; i < `MYCORE_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        model_pc = `MYCORE_RESET_PC;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        commits = 0;
        while (model_pc != END_PC) begin
            if (commits >= MAX_COMMITS) begin
                $display("reference model never reached the end of the program");
                stop_with_failure();
            end
            step_model(exp_pc, exp_reg, exp_data);
            wait_commit();
            check_commit(exp_pc, exp_reg, exp_data);
            commits++;
        end
        // the program has a fixed length and a fixed final sum
        assert (commits == EXPECTED_COMMITS) else begin
            $display("program ended after %0d commits instead of %0d",
                     commits, EXPECTED_COMMITS);
            stop_with_failure();
        end
        assert (commit_data == FINAL_SUM) else begin
            $display("ERR commit_data expected %h actual %h", FINAL_SUM, commit_data);
            stop_with_failure();
        end
        if (mycore_i.checker_i.error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

/* mycore.f */
+incdir+common
common/mycore_pkg.sv
design/fetch/fetch_unit.sv
design/decode.sv
design/regfile.sv
design/bypass.sv
design/execute.sv
design/mycore.sv
dv/mycore_checker.sv
dv/mycore_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mycore_tb
FILELIST ?= mycore.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -Wno-fatal
PASS_TEXT ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
